//--- booth_pkg.sv
package booth_pkg;

    // Operand width in bits
    localparam int MUL_WIDTH = 8;

    // Full signed product width
    localparam int PROD_WIDTH = 2 * MUL_WIDTH;

    // Accumulator carries one guard bit
    // so subtracting the most negative multiplicand stays in range
    localparam int ACC_WIDTH = MUL_WIDTH + 1;

    // Step counter must reach MUL_WIDTH itself
    localparam int CNT_WIDTH = $clog2(MUL_WIDTH + 1);

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_LOAD = 2'b01,
        ST_STEP = 2'b10,
        ST_DONE = 2'b11
    } booth_state_e;

    // Operation applied to the accumulator in one Booth step
    typedef enum logic [1:0] {
        ALU_NOP = 2'b00,
        ALU_ADD = 2'b01,
        ALU_SUB = 2'b10
    } alu_op_e;

endpackage

//--- booth_data_path.sv
module booth_data_path (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic signed [booth_pkg::MUL_WIDTH-1:0]  multiplicand,
    input  logic signed [booth_pkg::MUL_WIDTH-1:0]  multiplier,
    input  logic                                    clear,
    input  logic                                    load,
    input  logic                                    step,
    input  logic                                    show,
    input  booth_pkg::alu_op_e                      alu_op,
    output logic signed [booth_pkg::PROD_WIDTH-1:0] product,
    output logic        [1:0]                       q_pair,
    output logic                                    count_done
);
    import booth_pkg::*;

    // Accumulator, upper half of the running product plus guard bit
    logic signed [ACC_WIDTH-1:0]           acc;
    // Multiplier register, shifts into the lower product half
    logic signed [MUL_WIDTH-1:0]           mq;
    // Multiplicand held for the whole operation
    logic signed [MUL_WIDTH-1:0]           mcand;
    // Bit shifted out below mq, Q(-1) in Booth terms
    logic                                  q_extra;
    // Number of steps taken so far
    logic        [CNT_WIDTH-1:0]           count;

    // Multiplicand widened to accumulator size
    logic signed [ACC_WIDTH-1:0]           mcand_ext;
    // Accumulator after add, subtract or pass
    logic signed [ACC_WIDTH-1:0]           alu_out;
    // Accumulator and multiplier after the right shift
    logic signed [ACC_WIDTH+MUL_WIDTH-1:0] shift_out;

    // Sign extension by one bit
    assign mcand_ext = {mcand[MUL_WIDTH-1], mcand};

    // Add/subtract unit
    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                alu_out = acc + mcand_ext;
            end
            ALU_SUB: begin
                alu_out = acc - mcand_ext;
            end
            default: begin
                // 00 and 11 leave the accumulator alone
                alu_out = acc;
            end
        endcase
    end

    // Shift acc and mq right as one signed word
    // Sign bit of the new accumulator is replicated at the top
    assign shift_out = $signed({alu_out, mq}) >>> 1;

    // Booth pair seen by the controller
    assign q_pair = {mq[0], q_extra};

    // All steps taken
    assign count_done = (count == CNT_WIDTH'(MUL_WIDTH));

    // Guard bit dropped, result always fits in PROD_WIDTH
    assign product = show ? $signed({acc[MUL_WIDTH-1:0], mq}) : '0;

    // Operand and partial product registers
    always_ff @(posedge clk) begin
        if (clear) begin
            acc     <= '0;
            mq      <= '0;
            mcand   <= '0;
            q_extra <= 1'b0;
        end else if (load) begin
            // Capture operands, start from an empty accumulator
            acc     <= '0;
            mq      <= multiplier;
            mcand   <= multiplicand;
            q_extra <= 1'b0;
        end else if (step) begin
            acc     <= shift_out[ACC_WIDTH+MUL_WIDTH-1:MUL_WIDTH];
            mq      <= shift_out[MUL_WIDTH-1:0];
            // Old low multiplier bit becomes the new Q(-1)
            q_extra <= mq[0];
        end
    end

    // Step counter
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (clear || load) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- booth_controller.sv
module booth_controller (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  logic [1:0]         q_pair,
    input  logic               count_done,
    output logic               ack,
    output logic               clear,
    output logic               load,
    output logic               step,
    output logic               show,
    output booth_pkg::alu_op_e alu_op
);
    import booth_pkg::*;

    booth_state_e state;
    booth_state_e state_next;

    // State register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // Host request starts a multiplication
                if (req) begin
                    state_next = ST_LOAD;
                end
            end
            ST_LOAD: begin
                state_next = ST_STEP;
            end
            ST_STEP: begin
                // Counter reached MUL_WIDTH, product is complete
                if (count_done) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                // Hold the result until the host lets go of req
                if (!req) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // Idle keeps the datapath zeroed
    // so nothing stale reaches the next load
    assign clear = (state == ST_IDLE);

    // Single load cycle
    assign load = (state == ST_LOAD);

    // Step until the counter says stop
    // last STEP cycle only sees count_done and does no work
    assign step = (state == ST_STEP) && !count_done;

    // Result visible only while done
    assign show = (state == ST_DONE);
    assign ack  = (state == ST_DONE);

    // Booth recoding of {Q0, Q-1}
    always_comb begin
        alu_op = ALU_NOP;
        if (state == ST_STEP) begin
            case (q_pair)
                // End of a run of ones
                2'b01: begin
                    alu_op = ALU_ADD;
                end
                // Start of a run of ones
                2'b10: begin
                    alu_op = ALU_SUB;
                end
                // Inside a run, shift only
                default: begin
                    alu_op = ALU_NOP;
                end
            endcase
        end
    end

endmodule

//--- booth_multiplier.sv
module booth_multiplier (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    req,
    input  logic signed [booth_pkg::MUL_WIDTH-1:0]  multiplicand,
    input  logic signed [booth_pkg::MUL_WIDTH-1:0]  multiplier,
    output logic                                    ack,
    output logic signed [booth_pkg::PROD_WIDTH-1:0] product
);
    import booth_pkg::*;

    // Controller to datapath
    logic    clear;
    logic    load;
    logic    step;
    logic    show;
    alu_op_e alu_op;

    // Datapath status back to the controller
    logic [1:0] q_pair;
    logic       count_done;

    // Handshake and sequencing
    booth_controller booth_controller_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .q_pair     (q_pair),
        .count_done (count_done),
        .ack        (ack),
        .clear      (clear),
        .load       (load),
        .step       (step),
        .show       (show),
        .alu_op     (alu_op)
    );

    // Registers, add/subtract and shift
    booth_data_path booth_data_path_inst (
        .clk          (clk),
        .rst          (rst),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .clear        (clear),
        .load         (load),
        .step         (step),
        .show         (show),
        .alu_op       (alu_op),
        .product      (product),
        .q_pair       (q_pair),
        .count_done   (count_done)
    );

endmodule

//--- booth_multiplier_props.sv
module booth_multiplier_props (
    input logic                                    clk,
    input logic                                    rst,
    input logic                                    req,
    input logic                                    ack,
    input logic signed [booth_pkg::PROD_WIDTH-1:0] product,
    input booth_pkg::booth_state_e                 state
);
    timeunit 1ns;
    timeprecision 1ps;

    import booth_pkg::*;

    // Edges from the accepting edge to ack high
    localparam int ACK_LATENCY = MUL_WIDTH + 2;

    // ack is seen one tick after the edge that raised it
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    ack_holds: assert property (@(posedge clk) disable iff (!rst)
        (ack && req) |=> ack)
        else $error("ack dropped while req was still high");

    ack_release: assert property (@(posedge clk) disable iff (!rst)
        (ack && !req) |=> !ack)
        else $error("ack stayed high after req was sampled low");

    product_gated: assert property (@(posedge clk) disable iff (!rst)
        !ack |-> (product == '0))
        else $error("product nonzero while ack low");

    // Extra tick for the sampled view of ack
    ack_latency: assert property (@(posedge clk) disable iff (!rst)
        (state == ST_IDLE && req) |-> ##(ACK_LATENCY + 1) $rose(ack))
        else $error("ack latency differs from MUL_WIDTH+2 cycles");

endmodule

bind booth_multiplier booth_multiplier_props booth_multiplier_props_inst (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .ack     (ack),
    .product (product),
    .state   (booth_controller_inst.state)
);

//--- booth_multiplier_tb.sv
module booth_multiplier_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import booth_pkg::*;

    // About 225 transactions at no more than 25 cycles each, with margin
    localparam int TIMEOUT_CYCLES = 10000;
    localparam int RANDOM_COUNT   = 200;
    localparam int CORNER_COUNT   = 5;

    logic                         clk;
    logic                         rst;
    logic                         req;
    logic signed [MUL_WIDTH-1:0]  multiplicand;
    logic signed [MUL_WIDTH-1:0]  multiplier;
    logic                         ack;
    logic signed [PROD_WIDTH-1:0] product;

    int          error_count;
    int          check_count;
    int          cycle_count;
    int          launched_count;
    int          completed_count;
    logic [31:0] rng_state;

    booth_multiplier booth_multiplier_inst (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .ack          (ack),
        .product      (product)
    );

    // Full precision signed product, cut to the product width
    function automatic logic signed [PROD_WIDTH-1:0] ref_product(
        input logic signed [MUL_WIDTH-1:0] a,
        input logic signed [MUL_WIDTH-1:0] b
    );
        longint full;
        full = longint'(a) * longint'(b);
        return full[PROD_WIDTH-1:0];
    endfunction

    // 32-bit xorshift step
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Operands at the edges of the signed range
    function automatic logic signed [MUL_WIDTH-1:0] corner_value(input int idx);
        case (idx)
            0: return '0;
            1: return MUL_WIDTH'(1);
            2: return '1;
            // Largest positive
            3: return {1'b0, {(MUL_WIDTH-1){1'b1}}};
            // Most negative
            default: return {1'b1, {(MUL_WIDTH-1){1'b0}}};
        endcase
    endfunction

    task automatic check_value(input longint actual, input longint expected, input string what);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("[FAIL] time %0d ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    // One four-phase handshake, called and returning on a falling edge with ack low
    task automatic run_transaction(
        input logic signed [MUL_WIDTH-1:0] a,
        input logic signed [MUL_WIDTH-1:0] b,
        input int                          hold_cycles
    );
        multiplicand = a;
        multiplier   = b;
        req          = 1'b1;
        launched_count++;
        do begin
            @(negedge clk);
        end while (!ack);
        // Host keeps req up past ack
        repeat (hold_cycles) @(negedge clk);
        req = 1'b0;
        do begin
            @(negedge clk);
        end while (ack);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Product held while ack is up, zero once it drops
    initial begin : compare_results
        logic signed [PROD_WIDTH-1:0] expected;
        forever begin
            @(posedge ack);
            @(negedge clk);
            // Operands stay put until the next request
            expected = ref_product(multiplicand, multiplier);
            while (ack) begin
                check_value(longint'(product), longint'(expected), "product while ack high");
                @(negedge clk);
            end
            check_value(longint'(product), 0, "product after ack fell");
            completed_count++;
        end
    end

    initial begin : timeout_watch
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        error_count++;
        $display("Simulation timed out after %0d cycles, errors: %0d",
                 cycle_count, error_count);
        $display("Something failed");
        $finish;
    end

    initial begin : stimulus
        logic signed [MUL_WIDTH-1:0] a;
        logic signed [MUL_WIDTH-1:0] b;
        int                          hold;
        error_count     = 0;
        check_count     = 0;
        cycle_count     = 0;
        launched_count  = 0;
        completed_count = 0;
        rng_state       = 32'd73;
        rst             = 1'b0;
        req             = 1'b0;
        multiplicand    = '0;
        multiplier      = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // Idle outputs before any request
        @(negedge clk);
        check_value(longint'(ack), 0, "ack after reset");
        check_value(longint'(product), 0, "product after reset");

        // Every corner pair, back to back
        for (int i = 0; i < CORNER_COUNT; i++) begin
            for (int j = 0; j < CORNER_COUNT; j++) begin
                run_transaction(corner_value(i), corner_value(j), 0);
            end
        end

        // Random operands with 0 to 8 cycles of back-pressure
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            rng_state = next_random(rng_state);
            a         = rng_state[MUL_WIDTH-1:0];
            b         = rng_state[2*MUL_WIDTH-1:MUL_WIDTH];
            hold      = int'(rng_state[31:28]) % 9;
            run_transaction(a, b, hold);
        end

        // Let the last comparison finish
        @(negedge clk);
        check_value(longint'(completed_count), longint'(launched_count),
                    "completed transactions");
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sim.f
booth_pkg.sv
booth_data_path.sv
booth_controller.sv
booth_multiplier.sv
booth_multiplier_props.sv
booth_multiplier_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Booth multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
EXE=booth_sim

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module booth_multiplier_tb -f sim.f --Mdir "$OBJ" -o "$EXE"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Result is taken from the log only
if grep -q "^Everything OK$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
